// File: source/rvIsaPkg.sv
package rvIsaPkg;

    // =========================================================================
    // base types of the integer ISA.
    // =========================================================================
    typedef logic [31:0] word;
    typedef logic [31:0] instrWord;
    typedef logic [4:0]  regIdx;
    typedef logic [6:0]  opcode;

    localparam opcode opcAriRtype = 7'b0110011;
    localparam opcode opcAriItype = 7'b0010011;
    localparam opcode opcLui      = 7'b0110111;
    localparam opcode opcAuipc    = 7'b0010111;
    localparam opcode opcJal      = 7'b1101111;
    localparam opcode opcJalr     = 7'b1100111;
    localparam opcode opcBranch   = 7'b1100011;
    localparam opcode opcLoad     = 7'b0000011;
    localparam opcode opcStore    = 7'b0100011;

    // arithmetic funct3.
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Srl    = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Word = 3'b010; // lw and sw only.

    localparam logic [6:0] f7Sub = 7'b0100000;

endpackage

// File: source/pipeCtrlPkg.sv
package pipeCtrlPkg;

    typedef logic [13:0] pcAddr; // byte address, 4096 words.

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluPassB
    } aluOp;

    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbLink
    } wbSrc;

    typedef enum logic [2:0] {
        brNone,
        brEq,
        brNe,
        brLt,
        brGe,
        brJump
    } brCond;

endpackage

// File: source/dataMemIf.sv
`timescale 1ns/1ps

interface dataMemIf;

    logic          req;
    logic          ack;
    logic          we;
    rvIsaPkg::word addr;
    rvIsaPkg::word wdata;
    rvIsaPkg::word rdata; // valid while ack is high on a load.

    modport core (
        output req, we, addr, wdata,
        input  ack, rdata
    );

    modport mem (
        input  req, we, addr, wdata,
        output ack, rdata
    );

endinterface

// File: source/hazardController.sv
`timescale 1ns/1ps

module hazardController (
    input  logic               stall,
    input  rvIsaPkg::opcode    opcodeW,
    input  rvIsaPkg::opcode    opcodeX,
    input  rvIsaPkg::regIdx    rd,
    input  rvIsaPkg::regIdx    rs1,
    input  rvIsaPkg::regIdx    rs2,
    input  pipeCtrlPkg::pcAddr pcX,
    input  pipeCtrlPkg::pcAddr pcW,
    output logic               cwe2,
    output logic               forwardA,
    output logic               forwardB,
    output logic               delayW,
    output logic               delayX
);
    logic usesRs1;
    logic usesRs2;
    logic hitA;
    logic hitB;

    // which source fields X actually reads.
    always_comb begin
        case (opcodeX)
            rvIsaPkg::opcAriRtype, rvIsaPkg::opcBranch, rvIsaPkg::opcStore: begin
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
            end
            rvIsaPkg::opcAriItype, rvIsaPkg::opcLoad, rvIsaPkg::opcJalr: begin
                usesRs1 = 1'b1;
                usesRs2 = 1'b0;
            end
            default: begin
                usesRs1 = 1'b0;
                usesRs2 = 1'b0;
            end
        endcase
    end

    assign hitA = usesRs1 && (rd != '0) && (rd == rs1);
    assign hitB = usesRs2 && (rd != '0) && (rd == rs2);

    always_comb begin
        cwe2     = 1'b1;
        forwardA = 1'b0;
        forwardB = 1'b0;
        delayW   = 1'b0;
        delayX   = 1'b0;
        if (stall) begin // memory wait holds both stages.
            cwe2   = 1'b0;
            delayW = 1'b1;
            delayX = 1'b1;
        end else begin
            case (opcodeW)
                rvIsaPkg::opcAriRtype, rvIsaPkg::opcAriItype, rvIsaPkg::opcLui,
                rvIsaPkg::opcAuipc, rvIsaPkg::opcJal, rvIsaPkg::opcJalr: begin
                    forwardA = hitA && (pcX != pcW);
                    forwardB = hitB && (pcX != pcW);
                end
                rvIsaPkg::opcLoad: begin
                    cwe2   = !(hitA || hitB); // load-use, one bubble.
                    delayW = hitA || hitB;
                end
                default: begin
                    cwe2 = 1'b1;
                end
            endcase
        end
    end

endmodule

// File: source/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    input  logic            rstN,
    input  rvIsaPkg::regIdx raddrA,
    input  rvIsaPkg::regIdx raddrB,
    output rvIsaPkg::word   rdataA,
    output rvIsaPkg::word   rdataB,
    input  logic            we,
    input  rvIsaPkg::regIdx waddr,
    input  rvIsaPkg::word   wdata
);
    rvIsaPkg::word regs [32];

    assign rdataA = regs[raddrA];
    assign rdataB = regs[raddrB];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin // x0 stays zero.
            regs[waddr] <= wdata;
        end
    end

endmodule

// File: source/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  rvIsaPkg::instrWord  instr,
    output rvIsaPkg::regIdx     rs1,
    output rvIsaPkg::regIdx     rs2,
    output rvIsaPkg::regIdx     rd,
    output rvIsaPkg::word       imm,
    output pipeCtrlPkg::aluOp   op,
    output logic                useImm,
    output logic                regWrite,
    output logic                memRead,
    output logic                memWrite,
    output pipeCtrlPkg::wbSrc   wbSel,
    output pipeCtrlPkg::brCond  cond,
    output logic                srcPc,
    output rvIsaPkg::opcode     opc
);
    logic [2:0]        f3;
    logic              isSub;
    pipeCtrlPkg::aluOp arithOp;
    rvIsaPkg::word     immI;
    rvIsaPkg::word     immS;
    rvIsaPkg::word     immB;
    rvIsaPkg::word     immU;
    rvIsaPkg::word     immJ;

    assign opc = instr[6:0];
    assign rd  = instr[11:7];
    assign f3  = instr[14:12];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // sub only exists in the register form.
    assign isSub = (opc == rvIsaPkg::opcAriRtype) && (instr[31:25] == rvIsaPkg::f7Sub);

    always_comb begin
        case (f3)
            rvIsaPkg::f3AddSub: arithOp = isSub ? pipeCtrlPkg::aluSub : pipeCtrlPkg::aluAdd;
            rvIsaPkg::f3Sll:    arithOp = pipeCtrlPkg::aluSll;
            rvIsaPkg::f3Slt:    arithOp = pipeCtrlPkg::aluSlt;
            rvIsaPkg::f3Xor:    arithOp = pipeCtrlPkg::aluXor;
            rvIsaPkg::f3Srl:    arithOp = pipeCtrlPkg::aluSrl;
            rvIsaPkg::f3Or:     arithOp = pipeCtrlPkg::aluOr;
            rvIsaPkg::f3And:    arithOp = pipeCtrlPkg::aluAnd;
            default:            arithOp = pipeCtrlPkg::aluAdd;
        endcase
    end

    // =========================================================================
    // control per opcode, unknown ones fall through as a no-operation.
    // =========================================================================
    always_comb begin
        imm      = immI;
        op       = pipeCtrlPkg::aluAdd;
        useImm   = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        wbSel    = pipeCtrlPkg::wbAlu;
        cond     = pipeCtrlPkg::brNone;
        srcPc    = 1'b0;
        case (opc)
            rvIsaPkg::opcAriRtype: begin
                op       = arithOp;
                regWrite = 1'b1;
            end
            rvIsaPkg::opcAriItype: begin
                op       = arithOp;
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            rvIsaPkg::opcLui: begin
                imm      = immU;
                op       = pipeCtrlPkg::aluPassB;
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            rvIsaPkg::opcAuipc: begin
                imm      = immU;
                useImm   = 1'b1;
                srcPc    = 1'b1;
                regWrite = 1'b1;
            end
            rvIsaPkg::opcJal, rvIsaPkg::opcJalr: begin
                imm      = (opc == rvIsaPkg::opcJal) ? immJ : immI;
                regWrite = 1'b1;
                wbSel    = pipeCtrlPkg::wbLink;
                cond     = pipeCtrlPkg::brJump;
            end
            rvIsaPkg::opcBranch: begin
                imm = immB;
                case (f3)
                    rvIsaPkg::f3Beq: cond = pipeCtrlPkg::brEq;
                    rvIsaPkg::f3Bne: cond = pipeCtrlPkg::brNe;
                    rvIsaPkg::f3Blt: cond = pipeCtrlPkg::brLt;
                    rvIsaPkg::f3Bge: cond = pipeCtrlPkg::brGe;
                    default:         cond = pipeCtrlPkg::brNone;
                endcase
            end
            rvIsaPkg::opcLoad: begin
                useImm   = 1'b1;
                memRead  = (f3 == rvIsaPkg::f3Word);
                regWrite = (f3 == rvIsaPkg::f3Word);
                wbSel    = pipeCtrlPkg::wbMem;
            end
            rvIsaPkg::opcStore: begin
                imm      = immS;
                useImm   = 1'b1;
                memWrite = (f3 == rvIsaPkg::f3Word);
            end
            default: begin
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

// File: source/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  rvIsaPkg::word      a,
    input  rvIsaPkg::word      b,
    input  pipeCtrlPkg::aluOp  op,
    input  pipeCtrlPkg::brCond cond,
    output rvIsaPkg::word      result,
    output logic               taken
);
    always_comb begin
        case (op)
            pipeCtrlPkg::aluAdd:   result = a + b;
            pipeCtrlPkg::aluSub:   result = a - b;
            pipeCtrlPkg::aluAnd:   result = a & b;
            pipeCtrlPkg::aluOr:    result = a | b;
            pipeCtrlPkg::aluXor:   result = a ^ b;
            pipeCtrlPkg::aluSlt:   result = {31'b0, $signed(a) < $signed(b)};
            pipeCtrlPkg::aluSll:   result = a << b[4:0];
            pipeCtrlPkg::aluSrl:   result = a >> b[4:0];
            pipeCtrlPkg::aluPassB: result = b;
            default:               result = a + b;
        endcase
    end

    // compare on the raw register operands.
    always_comb begin
        case (cond)
            pipeCtrlPkg::brEq:   taken = (a == b);
            pipeCtrlPkg::brNe:   taken = (a != b);
            pipeCtrlPkg::brLt:   taken = ($signed(a) < $signed(b));
            pipeCtrlPkg::brGe:   taken = ($signed(a) >= $signed(b));
            pipeCtrlPkg::brJump: taken = 1'b1;
            default:             taken = 1'b0;
        endcase
    end

endmodule

// File: source/pipelineCore.sv
`timescale 1ns/1ps

module pipelineCore #(
    parameter int imemWordsLog2 = 12
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               run,
    output pipeCtrlPkg::pcAddr fetchAddr,
    input  rvIsaPkg::instrWord fetchInstr,
    dataMemIf.core             mem,
    output logic               retireValid,
    output pipeCtrlPkg::pcAddr retirePc,
    output rvIsaPkg::regIdx    retireRd,
    output rvIsaPkg::word      retireData
);
    localparam pipeCtrlPkg::pcAddr pcMask =
        pipeCtrlPkg::pcAddr'((1 << (imemWordsLog2 + 2)) - 1);

    pipeCtrlPkg::pcAddr pcF, pcX, pcW, target;
    logic               validX, validW, redirect, taken, stall, wbWe;
    rvIsaPkg::instrWord instrX;
    rvIsaPkg::regIdx    rs1X, rs2X, rdX, rdW;
    rvIsaPkg::word      immX, regA, regB, opA, opB, aluA, aluB, aluOut, tgtSum;
    rvIsaPkg::word      aluW, storeW, linkW, loadW, wbValue;
    pipeCtrlPkg::aluOp  opX;
    pipeCtrlPkg::wbSrc  wbSelX, wbSelW;
    pipeCtrlPkg::brCond condX;
    rvIsaPkg::opcode    opcX, opcW, hzOpcW;
    logic               useImmX, regWriteX, memReadX, memWriteX, srcPcX;
    logic               regWriteW, memReadW, memWriteW;
    logic               cwe2, forwardA, forwardB, delayW, delayX;

    // =========================================================================
    // fetch and X.
    // =========================================================================
    assign fetchAddr = cwe2 ? pcF : pcX; // re-read the held X word.
    assign instrX    = validX ? fetchInstr : '0;

    instrDecoder uDec (
        .instr(instrX), .rs1(rs1X), .rs2(rs2X), .rd(rdX), .imm(immX), .op(opX),
        .useImm(useImmX), .regWrite(regWriteX), .memRead(memReadX), .memWrite(memWriteX),
        .wbSel(wbSelX), .cond(condX), .srcPc(srcPcX), .opc(opcX)
    );

    regFile uRegs (
        .clk, .rstN, .raddrA(rs1X), .raddrB(rs2X), .rdataA(regA), .rdataB(regB),
        .we(wbWe), .waddr(rdW), .wdata(wbValue)
    );

    assign opA  = forwardA ? wbValue : regA;
    assign opB  = forwardB ? wbValue : regB;
    assign aluA = srcPcX ? rvIsaPkg::word'(pcX) : opA;
    assign aluB = useImmX ? immX : opB;

    aluUnit uAlu (.a(aluA), .b(aluB), .op(opX), .cond(condX), .result(aluOut), .taken);

    assign tgtSum   = ((opcX == rvIsaPkg::opcJalr) ? opA : rvIsaPkg::word'(pcX)) + immX;
    assign target   = {tgtSum[13:1], 1'b0};
    assign redirect = validX && taken;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcF    <= '0;
            pcX    <= '0;
            validX <= 1'b0;
        end else if (cwe2) begin
            pcX    <= pcF;
            validX <= run && !redirect; // kill F on redirect.
            if (run) begin
                pcF <= (redirect ? target : pcF + 14'd4) & pcMask;
            end
        end
    end

    // =========================================================================
    // W and the data memory handshake.
    // =========================================================================
    assign stall     = validW && (memReadW || memWriteW) && (mem.req || mem.ack);
    assign wbWe      = validW && regWriteW && !stall;
    assign hzOpcW    = validW ? opcW : '0;
    assign mem.we    = memWriteW;
    assign mem.addr  = aluW;
    assign mem.wdata = storeW;

    always_comb begin
        case (wbSelW)
            pipeCtrlPkg::wbMem:  wbValue = loadW;
            pipeCtrlPkg::wbLink: wbValue = linkW;
            default:             wbValue = aluW;
        endcase
    end

    hazardController uHaz (
        .stall, .opcodeW(hzOpcW), .opcodeX(opcX), .rd(rdW), .rs1(rs1X), .rs2(rs2X),
        .pcX, .pcW, .cwe2, .forwardA, .forwardB, .delayW, .delayX
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validW      <= 1'b0;
            mem.req     <= 1'b0;
            retireValid <= 1'b0;
        end else begin
            if (!delayW) begin
                validW <= validX;
            end else if (!delayX) begin
                validW <= 1'b0; // bubble behind a load.
            end
            if (mem.req && mem.ack) begin
                mem.req <= 1'b0;
            end else if (!delayW && validX && (memReadX || memWriteX)) begin
                mem.req <= 1'b1;
            end
            retireValid <= validW && !stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!delayW) begin
            pcW       <= pcX;
            rdW       <= rdX;
            aluW      <= aluOut;
            storeW    <= opB;
            linkW     <= rvIsaPkg::word'(pcX) + 32'd4;
            regWriteW <= regWriteX;
            memReadW  <= memReadX;
            memWriteW <= memWriteX;
            wbSelW    <= wbSelX;
            opcW      <= opcX;
        end
        if (mem.req && mem.ack) begin
            loadW <= mem.rdata;
        end
        retirePc   <= pcW;
        retireRd   <= regWriteW ? rdW : '0;
        retireData <= (regWriteW && (rdW != '0)) ? wbValue : '0;
    end

endmodule

// File: source/instrMem.sv
`timescale 1ns/1ps

module instrMem #(
    parameter int imemWordsLog2 = 12
) (
    input  logic               clk,
    input  logic               we,
    input  pipeCtrlPkg::pcAddr waddr,
    input  rvIsaPkg::instrWord wdata,
    input  pipeCtrlPkg::pcAddr raddr,
    output rvIsaPkg::instrWord rdata
);
    rvIsaPkg::instrWord ram [2**imemWordsLog2];

    always_ff @(posedge clk) begin
        if (we) begin
            ram[waddr[imemWordsLog2+1:2]] <= wdata; // word addressed.
        end
        rdata <= ram[raddr[imemWordsLog2+1:2]];
    end

endmodule

// File: source/dataMem.sv
`timescale 1ns/1ps

module dataMem #(
    parameter int dataWordsLog2 = 8,
    parameter int ackDelay      = 2
) (
    input logic   clk,
    input logic   rstN,
    dataMemIf.mem bus
);
    localparam int              cntW    = (ackDelay > 0) ? $clog2(ackDelay + 1) : 1;
    localparam logic [cntW-1:0] lastCnt = cntW'(ackDelay);

    typedef enum logic [1:0] {
        memIdle,
        memWait,
        memAck
    } memState;

    memState                  state;
    logic [cntW-1:0]          cnt;
    logic                     fire;
    logic [dataWordsLog2-1:0] wordAddr;
    rvIsaPkg::word            ram [2**dataWordsLog2];

    assign wordAddr = bus.addr[dataWordsLog2+1:2];
    // access happens on the cycle ack rises.
    assign fire = ((state == memWait) || (state == memIdle && bus.req)) && (cnt == lastCnt);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= memIdle;
            cnt     <= '0;
            bus.ack <= 1'b0;
        end else begin
            case (state)
                memIdle, memWait: begin
                    if (fire) begin
                        bus.ack <= 1'b1;
                        cnt     <= '0;
                        state   <= memAck;
                    end else if (bus.req || state == memWait) begin
                        cnt   <= cnt + 1'b1;
                        state <= memWait;
                    end
                end
                memAck: begin
                    if (!bus.req) begin // phase four.
                        bus.ack <= 1'b0;
                        state   <= memIdle;
                    end
                end
                default: state <= memIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fire && bus.we) begin
            ram[wordAddr] <= bus.wdata;
        end else if (fire) begin
            bus.rdata <= ram[wordAddr];
        end
    end

endmodule

// File: source/riscPipeTop.sv
`timescale 1ns/1ps

module riscPipeTop #(
    parameter int imemWordsLog2 = 12,
    parameter int dataWordsLog2 = 8,
    parameter int ackDelay      = 2
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               imemWe,
    input  pipeCtrlPkg::pcAddr imemAddr,
    input  rvIsaPkg::instrWord imemWdata,
    input  logic               run,
    output logic               retireValid,
    output pipeCtrlPkg::pcAddr retirePc,
    output rvIsaPkg::regIdx    retireRd,
    output rvIsaPkg::word      retireData
);
    pipeCtrlPkg::pcAddr fetchAddr;
    rvIsaPkg::instrWord fetchInstr;

    dataMemIf dmem ();

    pipelineCore #(
        .imemWordsLog2(imemWordsLog2)
    ) uCore (
        .clk,
        .rstN,
        .run,
        .fetchAddr,
        .fetchInstr,
        .mem(dmem.core),
        .retireValid,
        .retirePc,
        .retireRd,
        .retireData
    );

    instrMem #(
        .imemWordsLog2(imemWordsLog2)
    ) uImem (
        .clk,
        .we(imemWe),
        .waddr(imemAddr),
        .wdata(imemWdata),
        .raddr(fetchAddr),
        .rdata(fetchInstr)
    );

    dataMem #(
        .dataWordsLog2(dataWordsLog2),
        .ackDelay(ackDelay)
    ) uDmem (
        .clk,
        .rstN,
        .bus(dmem.mem)
    );

endmodule

// File: tests/tbClockGen.sv
`timescale 1ns/1ps

module tbClockGen #(
    parameter int halfPeriodNs = 4 // 8 ns period.
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #(halfPeriodNs) clk = ~clk;
        end
    end

endmodule

// File: tests/riscPipeTb.sv
`timescale 1ns/1ps

module riscPipeTb;

    localparam int ackDelay      = 2;
    localparam int resetCycles   = 16;
    localparam int progWords     = 44;
    localparam int numExpect     = 34;
    localparam int memOps        = 2;
    localparam int timeoutCycles = resetCycles + progWords + 8
                                   + numExpect * 40 + memOps * ackDelay;

    localparam logic [6:0] opRtype  = 7'b0110011;
    localparam logic [6:0] opItype  = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;

    logic        clk;
    logic        rstN;
    logic        imemWe;
    logic [13:0] imemAddr;
    logic [31:0] imemWdata;
    logic        run;
    logic        retireValid;
    logic [13:0] retirePc;
    logic [4:0]  retireRd;
    logic [31:0] retireData;

    logic [31:0] prog [progWords];
    string       expName [numExpect];
    logic [13:0] expPc [numExpect];
    logic [4:0]  expRd [numExpect];
    logic [31:0] expData [numExpect];
    int          expCount;
    int          seenCount;

    tbClockGen clkGen (.clk);

    riscPipeTop #(
        .ackDelay(ackDelay)
    ) uut (
        .clk,
        .rstN,
        .imemWe,
        .imemAddr,
        .imemWdata,
        .run,
        .retireValid,
        .retirePc,
        .retireRd,
        .retireData
    );

    // =========================================================================
    // instruction encoders.
    // =========================================================================
    function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, opRtype};
    endfunction

    function automatic logic [31:0] encodeI(input logic [6:0] opc, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encodeS(input logic [2:0] f3, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encodeB(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] encodeU(input logic [6:0] opc, input logic [4:0] rd,
                                            input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] encodeJ(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    // =========================================================================
    // program table, index is pc / 4.
    // =========================================================================
    task automatic buildProgram();
        prog[0]  = encodeI(opItype, 3'b000, 5'd1, 5'd0, 12'd5);
        prog[1]  = encodeI(opItype, 3'b000, 5'd2, 5'd0, 12'd12);
        prog[2]  = encodeR(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2); // add, fwd x2.
        prog[3]  = encodeR(7'b0100000, 3'b000, 5'd4, 5'd3, 5'd1); // sub.
        prog[4]  = encodeR(7'b0000000, 3'b111, 5'd5, 5'd4, 5'd2);
        prog[5]  = encodeR(7'b0000000, 3'b110, 5'd6, 5'd5, 5'd1);
        prog[6]  = encodeR(7'b0000000, 3'b100, 5'd7, 5'd6, 5'd2);
        prog[7]  = encodeR(7'b0000000, 3'b010, 5'd8, 5'd4, 5'd3);
        prog[8]  = encodeR(7'b0000000, 3'b001, 5'd9, 5'd1, 5'd8);
        prog[9]  = encodeR(7'b0000000, 3'b101, 5'd10, 5'd2, 5'd8);
        prog[10] = encodeI(opItype, 3'b000, 5'd11, 5'd0, 12'hFFD); // -3.
        prog[11] = encodeI(opItype, 3'b010, 5'd12, 5'd11, 12'h000);
        prog[12] = encodeI(opItype, 3'b100, 5'd13, 5'd11, 12'hFFF);
        prog[13] = encodeI(opItype, 3'b110, 5'd14, 5'd1, 12'h030);
        prog[14] = encodeI(opItype, 3'b111, 5'd15, 5'd14, 12'h00F);
        prog[15] = encodeI(opItype, 3'b001, 5'd16, 5'd15, 12'd4);
        prog[16] = encodeI(opItype, 3'b101, 5'd17, 5'd11, 12'd28);
        prog[17] = encodeU(opLui, 5'd18, 20'h12345);
        prog[18] = encodeU(opAuipc, 5'd19, 20'h00001);
        prog[19] = encodeI(opItype, 3'b000, 5'd0, 5'd1, 12'd7);   // write to x0.
        prog[20] = encodeR(7'b0000000, 3'b000, 5'd20, 5'd0, 5'd1);
        prog[21] = encodeI(opItype, 3'b000, 5'd21, 5'd0, 12'h040);
        prog[22] = encodeS(3'b010, 5'd18, 5'd21, 12'd8);
        prog[23] = encodeI(opLoad, 3'b010, 5'd22, 5'd21, 12'd8);
        prog[24] = encodeI(opItype, 3'b000, 5'd23, 5'd22, 12'd1); // load-use.
        prog[25] = encodeR(7'b0000000, 3'b000, 5'd24, 5'd22, 5'd23);
        prog[26] = encodeB(3'b000, 5'd1, 5'd20, 13'd8);           // beq taken.
        prog[27] = encodeI(opItype, 3'b000, 5'd25, 5'd0, 12'd99);
        prog[28] = encodeB(3'b001, 5'd1, 5'd1, 13'd8);            // bne not taken.
        prog[29] = encodeB(3'b100, 5'd11, 5'd1, 13'd8);           // blt taken.
        prog[30] = encodeI(opItype, 3'b000, 5'd25, 5'd0, 12'd77);
        prog[31] = encodeJ(5'd26, 21'd12);
        prog[32] = encodeI(opItype, 3'b000, 5'd25, 5'd0, 12'd55);
        prog[33] = encodeI(opItype, 3'b000, 5'd25, 5'd0, 12'd44);
        prog[34] = encodeI(opItype, 3'b000, 5'd27, 5'd0, 12'h0A0);
        prog[35] = encodeI(opJalr, 3'b000, 5'd28, 5'd27, 12'd0);
        prog[36] = encodeI(opItype, 3'b000, 5'd25, 5'd0, 12'd33);
        for (int i = 37; i < 40; i++) begin
            prog[i] = encodeI(opItype, 3'b000, 5'd25, 5'd0, 12'd11); // never reached.
        end
        prog[40] = encodeB(3'b101, 5'd1, 5'd11, 13'd8);           // bge taken.
        prog[41] = encodeI(opItype, 3'b000, 5'd25, 5'd0, 12'd22);
        prog[42] = encodeR(7'b0000000, 3'b000, 5'd29, 5'd26, 5'd28);
        prog[43] = encodeJ(5'd0, 21'd0); // parks the core.
    endtask

    task automatic addExpect(input string name, input logic [13:0] pc,
                             input logic [4:0] rd, input logic [31:0] data);
        expName[expCount] = name;
        expPc[expCount]   = pc;
        expRd[expCount]   = rd;
        expData[expCount] = data;
        expCount++;
    endtask

    // expected retirements in order, killed slots left out.
    task automatic buildExpected();
        addExpect("addi x1", 14'h000, 5'd1, 32'd5);
        addExpect("addi x2", 14'h004, 5'd2, 32'd12);
        addExpect("add fwd", 14'h008, 5'd3, 32'd17);
        addExpect("sub fwd", 14'h00C, 5'd4, 32'd12);
        addExpect("and fwd", 14'h010, 5'd5, 32'd12);
        addExpect("or fwd", 14'h014, 5'd6, 32'd13);
        addExpect("xor fwd", 14'h018, 5'd7, 32'd1);
        addExpect("slt", 14'h01C, 5'd8, 32'd1);
        addExpect("sll fwd", 14'h020, 5'd9, 32'd10);
        addExpect("srl", 14'h024, 5'd10, 32'd6);
        addExpect("addi neg", 14'h028, 5'd11, 32'hFFFF_FFFD);
        addExpect("slti", 14'h02C, 5'd12, 32'd1);
        addExpect("xori", 14'h030, 5'd13, 32'd2);
        addExpect("ori", 14'h034, 5'd14, 32'h35);
        addExpect("andi", 14'h038, 5'd15, 32'd5);
        addExpect("slli", 14'h03C, 5'd16, 32'h50);
        addExpect("srli", 14'h040, 5'd17, 32'hF);
        addExpect("lui", 14'h044, 5'd18, 32'h1234_5000);
        addExpect("auipc", 14'h048, 5'd19, 32'h0000_1048);
        addExpect("write x0", 14'h04C, 5'd0, 32'd0);
        addExpect("read x0", 14'h050, 5'd20, 32'd5);
        addExpect("addi base", 14'h054, 5'd21, 32'h40);
        addExpect("sw", 14'h058, 5'd0, 32'd0);
        addExpect("lw", 14'h05C, 5'd22, 32'h1234_5000);
        addExpect("load use", 14'h060, 5'd23, 32'h1234_5001);
        addExpect("add after load", 14'h064, 5'd24, 32'h2468_A001);
        addExpect("beq taken", 14'h068, 5'd0, 32'd0);
        addExpect("bne not taken", 14'h070, 5'd0, 32'd0);
        addExpect("blt taken", 14'h074, 5'd0, 32'd0);
        addExpect("jal link", 14'h07C, 5'd26, 32'h80);
        addExpect("jal target", 14'h088, 5'd27, 32'hA0);
        addExpect("jalr link", 14'h08C, 5'd28, 32'h90);
        addExpect("bge taken", 14'h0A0, 5'd0, 32'd0);
        addExpect("add links", 14'h0A8, 5'd29, 32'h110);
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progWords; i++) begin
            @(posedge clk);
            imemWe    <= 1'b1;
            imemAddr  <= 14'(i * 4);
            imemWdata <= prog[i];
        end
        @(posedge clk);
        imemWe <= 1'b0;
    endtask

    // one call per retireValid cycle, sampled mid-period.
    task automatic waitRetire();
        do begin
            @(negedge clk);
        end while (retireValid !== 1'b1);
    endtask

    // =========================================================================
    // checks.
    // =========================================================================
    always @(negedge clk) begin
        if (rstN === 1'b1 && run === 1'b0) begin
            assert (retireValid === 1'b0) else begin
                $display("retireValid went high while the core was not running");
                $display(">>> FAIL");
                $fatal(1);
            end
        end
    end

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("retirement stream stalled after %0d of %0d retirements",
                 seenCount, numExpect);
        $display(">>> FAIL");
        $fatal(1);
    end

    initial begin
        rstN      = 1'b0;
        imemWe    = 1'b0;
        imemAddr  = '0;
        imemWdata = '0;
        run       = 1'b0;
        expCount  = 0;
        seenCount = 0;
        buildProgram();
        buildExpected();
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        loadProgram();
        repeat (4) @(posedge clk); // idle window before run.
        run <= 1'b1;

        for (int i = 0; i < numExpect; i++) begin
            waitRetire();
            seenCount++;
            assert (retirePc === expPc[i]) else begin
                $display("FAIL %s pc expected %h actual %h", expName[i], expPc[i], retirePc);
                $display(">>> FAIL");
                $fatal(1);
            end
            assert (retireRd === expRd[i]) else begin
                $display("FAIL %s rd expected %0d actual %0d", expName[i], expRd[i], retireRd);
                $display(">>> FAIL");
                $fatal(1);
            end
            assert (retireData === expData[i]) else begin
                $display("FAIL %s data expected %h actual %h",
                         expName[i], expData[i], retireData);
                $display(">>> FAIL");
                $fatal(1);
            end
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: riscPipe.f
source/rvIsaPkg.sv
source/pipeCtrlPkg.sv
source/dataMemIf.sv
source/hazardController.sv
source/regFile.sv
source/instrDecoder.sv
source/aluUnit.sv
source/pipelineCore.sv
source/instrMem.sv
source/dataMem.sv
source/riscPipeTop.sv
tests/tbClockGen.sv
tests/riscPipeTb.sv
